// File: flist.f
verilog/mgmt_pkg.sv
verilog/axil_cmd_bridge.sv
verilog/dex_cmd_parse.sv
verilog/ctrl_cmd_parse.sv
verilog/pkt_discard_counter.sv
verilog/mgmt_reg_subsystem.sv
tests/tb_checker.sv
tests/tb_top.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_top -f flist.f -o tb_sim > sim.log 2>&1 &&
    ./obj_dir/tb_sim >> sim.log 2>&1 ||
    echo "Simulation failed" >> sim.log
cat sim.log
if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0

// File: tests/tb_top.sv
module tb_top
    import mgmt_pkg::*;
();

    localparam int AXI_ADDR_W     = 22;
    localparam int TIMEOUT_CYCLES = 4000;

    typedef struct packed {
        axi_resp_t  resp;
        mgmt_data_t data;
    } rd_exp_t;

    logic                  clk;
    logic                  rst_n;
    logic                  awvalid;
    logic                  awready;
    logic [AXI_ADDR_W-1:0] awaddr;
    logic                  wvalid;
    logic                  wready;
    mgmt_data_t            wdata;
    logic                  bvalid;
    logic                  bready;
    axi_resp_t             bresp;
    logic                  arvalid;
    logic                  arready;
    logic [AXI_ADDR_W-1:0] araddr;
    logic                  rvalid;
    logic                  rready;
    mgmt_data_t            rdata;
    axi_resp_t             rresp;
    logic                  pkt_discard;

    // Expectation strobe towards the checker
    logic                  exp_push;
    logic                  exp_is_rd;
    axi_resp_t             exp_resp;
    mgmt_data_t            exp_data;

    int                    pass_cnt;
    int                    fail_cnt;
    int                    pending;
    int                    cycles = 0;

    // Model of the control register and the counter
    logic                  m_en;
    mgmt_data_t            m_cnt;

    always #5 clk = ~clk;

    mgmt_reg_subsystem #(
        .AXI_ADDR_W (AXI_ADDR_W)
    ) UUT (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_awvalid     (awvalid),
        .o_awready     (awready),
        .i_awaddr      (awaddr),
        .i_wvalid      (wvalid),
        .o_wready      (wready),
        .i_wdata       (wdata),
        .o_bvalid      (bvalid),
        .i_bready      (bready),
        .o_bresp       (bresp),
        .i_arvalid     (arvalid),
        .o_arready     (arready),
        .i_araddr      (araddr),
        .o_rvalid      (rvalid),
        .i_rready      (rready),
        .o_rdata       (rdata),
        .o_rresp       (rresp),
        .i_pkt_discard (pkt_discard)
    );

    tb_checker u_checker (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_awready   (awready),
        .i_wready    (wready),
        .i_arvalid   (arvalid),
        .i_arready   (arready),
        .i_bvalid    (bvalid),
        .i_bready    (bready),
        .i_bresp     (bresp),
        .i_rvalid    (rvalid),
        .i_rready    (rready),
        .i_rdata     (rdata),
        .i_rresp     (rresp),
        .i_exp_push  (exp_push),
        .i_exp_is_rd (exp_is_rd),
        .i_exp_resp  (exp_resp),
        .i_exp_data  (exp_data),
        .o_pass_cnt  (pass_cnt),
        .o_fail_cnt  (fail_cnt),
        .o_pending   (pending)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the test sequence did not finish", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////
    function automatic logic [AXI_ADDR_W-1:0] make_axi_addr(input logic fixed,
                                                           input mgmt_addr_t addr);
        return {fixed, addr, 2'b00};
    endfunction

    function automatic rd_exp_t ref_read(input logic fixed, input mgmt_addr_t addr);
        rd_exp_t r;
        if (fixed && addr == ADDR_DISCARD_CNT) begin
            r = '{resp: RESP_OKAY, data: m_cnt};
        end else if (fixed && addr == ADDR_CNT_CTRL) begin
            // Clear bit is never stored
            r = '{resp: RESP_OKAY, data: {31'd0, m_en}};
        end else begin
            r = '{resp: RESP_SLVERR, data: '0};
        end
        return r;
    endfunction

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic push_expect(input logic is_rd, input axi_resp_t resp, input mgmt_data_t data);
        @(posedge clk);
        exp_push  <= 1'b1;
        exp_is_rd <= is_rd;
        exp_resp  <= resp;
        exp_data  <= data;
        @(posedge clk);
        exp_push  <= 1'b0;
    endtask

    task automatic axi_write(input logic fixed, input mgmt_addr_t addr, input mgmt_data_t data);
        int unsigned stall;
        stall = $urandom_range(0, 6);
        push_expect(1'b0, RESP_OKAY, '0);
        awvalid <= 1'b1;
        awaddr  <= make_axi_addr(fixed, addr);
        wvalid  <= 1'b1;
        wdata   <= data;
        @(negedge clk);
        while (!(awready && wready)) @(negedge clk);
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        // Host stalls before taking the response
        repeat (stall) @(posedge clk);
        bready <= 1'b1;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        @(posedge clk);
        bready <= 1'b0;
        if (fixed && addr == ADDR_CNT_CTRL) begin
            m_en = data[0];
            if (data[1]) begin
                m_cnt = '0;
            end
        end
        // Lets the enable and clear reach the counter
        idle_cycles(2);
    endtask

    task automatic axi_read(input logic fixed, input mgmt_addr_t addr);
        rd_exp_t     expected;
        int unsigned stall;
        expected = ref_read(fixed, addr);
        stall    = $urandom_range(0, 6);
        push_expect(1'b1, expected.resp, expected.data);
        arvalid <= 1'b1;
        araddr  <= make_axi_addr(fixed, addr);
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        arvalid <= 1'b0;
        repeat (stall) @(posedge clk);
        rready <= 1'b1;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic discard_burst(input int unsigned len);
        logic pulse;
        for (int unsigned i = 0; i < len; i++) begin
            pulse = ($urandom_range(0, 1) == 1);
            @(posedge clk);
            pkt_discard <= pulse;
            if (pulse && m_en && m_cnt != '1) begin
                m_cnt = m_cnt + 32'd1;
            end
        end
        @(posedge clk);
        pkt_discard <= 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////
    initial begin
        int unsigned seed_val;
        int unsigned sel;
        clk      = 1'b0;
        seed_val = $urandom(32'hd60e);
        m_en     = 1'b0;
        m_cnt    = '0;
        rst_n       <= 1'b0;
        awvalid     <= 1'b0;
        awaddr      <= '0;
        wvalid      <= 1'b0;
        wdata       <= '0;
        bready      <= 1'b0;
        arvalid     <= 1'b0;
        araddr      <= '0;
        rready      <= 1'b0;
        pkt_discard <= 1'b0;
        exp_push    <= 1'b0;
        exp_is_rd   <= 1'b0;
        exp_resp    <= '0;
        exp_data    <= '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        idle_cycles(2);

        // Enable, count a burst, read it back
        axi_write(1'b1, ADDR_CNT_CTRL, 32'h1);
        axi_read(1'b1, ADDR_CNT_CTRL);
        discard_burst($urandom_range(20, 60));
        axi_read(1'b1, ADDR_DISCARD_CNT);

        // Disabled counter holds its value
        axi_write(1'b1, ADDR_CNT_CTRL, 32'h0);
        axi_read(1'b1, ADDR_CNT_CTRL);
        discard_burst($urandom_range(20, 60));
        axi_read(1'b1, ADDR_DISCARD_CNT);

        // Clear together with enable, then counting resumes
        axi_write(1'b1, ADDR_CNT_CTRL, 32'h3);
        axi_read(1'b1, ADDR_DISCARD_CNT);
        axi_read(1'b1, ADDR_CNT_CTRL);
        discard_burst($urandom_range(20, 60));
        axi_read(1'b1, ADDR_DISCARD_CNT);

        // Clear alone leaves counting off
        axi_write(1'b1, ADDR_CNT_CTRL, 32'h2);
        axi_read(1'b1, ADDR_DISCARD_CNT);
        discard_burst($urandom_range(10, 30));
        axi_read(1'b1, ADDR_DISCARD_CNT);

        // Unowned addresses, fixed and table space
        axi_write(1'b1, ADDR_CNT_CTRL, 32'h1);
        discard_burst($urandom_range(10, 30));
        axi_read(1'b1, 19'd2);
        axi_read(1'b0, ADDR_DISCARD_CNT);
        axi_write(1'b1, 19'd2, 32'h0);
        axi_write(1'b0, ADDR_CNT_CTRL, 32'h2);
        axi_read(1'b1, ADDR_CNT_CTRL);
        axi_read(1'b1, ADDR_DISCARD_CNT);

        // Random mix, back-pressure comes from the tasks
        for (int i = 0; i < 10; i++) begin
            sel = $urandom_range(0, 3);
            case (sel)
                0: axi_read(1'b1, ADDR_DISCARD_CNT);
                1: axi_read(1'b1, ADDR_CNT_CTRL);
                2: axi_write(1'b1, ADDR_CNT_CTRL, $urandom_range(0, 3));
                default: discard_burst($urandom_range(1, 40));
            endcase
        end

        idle_cycles(10);
        if (pending != 0) begin
            $display("%0d expected responses never arrived", pending);
        end
        $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt + pending);
        if (fail_cnt == 0 && pending == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: tests/tb_checker.sv
module tb_checker
    import mgmt_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_awready,
    input  logic       i_wready,
    input  logic       i_arvalid,
    input  logic       i_arready,
    input  logic       i_bvalid,
    input  logic       i_bready,
    input  axi_resp_t  i_bresp,
    input  logic       i_rvalid,
    input  logic       i_rready,
    input  mgmt_data_t i_rdata,
    input  axi_resp_t  i_rresp,

    // Expected responses in issue order
    input  logic       i_exp_push,
    input  logic       i_exp_is_rd,
    input  axi_resp_t  i_exp_resp,
    input  mgmt_data_t i_exp_data,

    output int         o_pass_cnt,
    output int         o_fail_cnt,
    output int         o_pending
);

    typedef struct packed {
        logic       is_rd;
        axi_resp_t  resp;
        mgmt_data_t data;
    } exp_t;

    exp_t       exp_q[$];
    exp_t       incoming;
    int         n_test    = 0;
    int         pass_n    = 0;
    int         fail_n    = 0;
    int         pending_n = 0;
    logic       ar_wait   = 1'b0;
    int         ar_cycles = 0;
    logic       r_hold    = 1'b0;
    logic       b_hold    = 1'b0;
    mgmt_data_t r_data_held;
    axi_resp_t  r_resp_held;

    assign o_pass_cnt = pass_n;
    assign o_fail_cnt = fail_n;
    assign o_pending  = pending_n;

    task automatic note_failure(input string msg);
        fail_n++;
        $display("FAIL at %0t: %s", $time, msg);
    endtask

    task automatic check_response(input logic is_rd, input mgmt_data_t data,
                                  input axi_resp_t resp);
        exp_t  e;
        string kind;
        kind = is_rd ? "read" : "write";
        if (exp_q.size() == 0) begin
            note_failure({kind, " response arrived with nothing expected"});
        end else begin
            e = exp_q.pop_front();
            n_test++;
            if (e.is_rd != is_rd) begin
                note_failure($sformatf("test %0d got a %s response of the wrong kind",
                                       n_test, kind));
            end else if (data !== e.data || resp !== e.resp) begin
                fail_n++;
                if (data !== e.data) begin
                    $display("MISMATCH o_rdata test %0d: expected %h, got %h",
                             n_test, e.data, data);
                end
                if (resp !== e.resp) begin
                    $display("MISMATCH %s test %0d: expected %h, got %h",
                             is_rd ? "o_rresp" : "o_bresp", n_test, e.resp, resp);
                end
            end else begin
                pass_n++;
                $display("Test %0d %s ok: data %h resp %h", n_test, kind, data, resp);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Sampled at negedge so handshakes land on the next rising edge
    always @(negedge i_clk) begin
        if (i_rst_n) begin
            if (i_exp_push) begin
                incoming = '{is_rd: i_exp_is_rd, resp: i_exp_resp, data: i_exp_data};
                exp_q.push_back(incoming);
            end
            // No new address while a response waits
            if ((i_bvalid || i_rvalid) && (i_awready || i_wready || i_arready)) begin
                note_failure("address channel ready while a response is pending");
            end
            if (r_hold && (!i_rvalid || i_rdata !== r_data_held || i_rresp !== r_resp_held)) begin
                note_failure("read response changed before RREADY");
            end
            if (b_hold && !i_bvalid) begin
                note_failure("BVALID dropped before BREADY");
            end
            r_hold      = i_rvalid && !i_rready;
            b_hold      = i_bvalid && !i_bready;
            r_data_held = i_rdata;
            r_resp_held = i_rresp;
            // RVALID is due three cycles after the AR handshake
            if (ar_wait) begin
                ar_cycles++;
                if (i_rvalid) begin
                    ar_wait = 1'b0;
                    if (ar_cycles != 3) begin
                        note_failure($sformatf("RVALID came %0d cycles after the AR handshake",
                                               ar_cycles));
                    end
                end else if (ar_cycles >= 3) begin
                    ar_wait = 1'b0;
                    note_failure("RVALID did not rise 3 cycles after the AR handshake");
                end
            end
            if (i_arvalid && i_arready) begin
                ar_wait   = 1'b1;
                ar_cycles = 0;
            end
            if (i_rvalid && i_rready) begin
                check_response(1'b1, i_rdata, i_rresp);
            end
            if (i_bvalid && i_bready) begin
                check_response(1'b0, '0, i_bresp);
            end
            pending_n = exp_q.size();
        end
    end

endmodule

// File: verilog/mgmt_reg_subsystem.sv
module mgmt_reg_subsystem
    import mgmt_pkg::*;
#(
    parameter int AXI_ADDR_W = 22
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,

    // AXI4-Lite slave
    input  logic                  i_awvalid,
    output logic                  o_awready,
    input  logic [AXI_ADDR_W-1:0] i_awaddr,
    input  logic                  i_wvalid,
    output logic                  o_wready,
    input  mgmt_data_t            i_wdata,
    output logic                  o_bvalid,
    input  logic                  i_bready,
    output axi_resp_t             o_bresp,
    input  logic                  i_arvalid,
    output logic                  o_arready,
    input  logic [AXI_ADDR_W-1:0] i_araddr,
    output logic                  o_rvalid,
    input  logic                  i_rready,
    output mgmt_data_t            o_rdata,
    output axi_resp_t             o_rresp,

    // Discard events from the data path
    input  logic                  i_pkt_discard
);

    localparam int N_RSP = 2;

    mgmt_cmd_t              cmd;
    mgmt_rsp_t [N_RSP-1:0]  rsp;
    logic                   cnt_en;
    logic                   cnt_clr;
    mgmt_data_t             discard_cnt;

    //////////////////////////////////////////////////
    // Host side
    //////////////////////////////////////////////////
    axil_cmd_bridge #(
        .N_RSP      (N_RSP),
        .AXI_ADDR_W (AXI_ADDR_W)
    ) u_bridge (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_awvalid (i_awvalid),
        .o_awready (o_awready),
        .i_awaddr  (i_awaddr),
        .i_wvalid  (i_wvalid),
        .o_wready  (o_wready),
        .i_wdata   (i_wdata),
        .o_bvalid  (o_bvalid),
        .i_bready  (i_bready),
        .o_bresp   (o_bresp),
        .i_arvalid (i_arvalid),
        .o_arready (o_arready),
        .i_araddr  (i_araddr),
        .o_rvalid  (o_rvalid),
        .i_rready  (i_rready),
        .o_rdata   (o_rdata),
        .o_rresp   (o_rresp),
        .o_cmd     (cmd),
        .i_rsp     (rsp)
    );

    //////////////////////////////////////////////////
    // Register blocks
    //////////////////////////////////////////////////
    dex_cmd_parse u_dex_parse (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .i_cmd              (cmd),
        .iv_pkt_discard_cnt (discard_cnt),
        .o_rsp              (rsp[0])
    );

    ctrl_cmd_parse u_ctrl_parse (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_cmd     (cmd),
        .o_rsp     (rsp[1]),
        .o_cnt_en  (cnt_en),
        .o_cnt_clr (cnt_clr)
    );

    pkt_discard_counter u_discard_cnt (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .i_pkt_discard      (i_pkt_discard),
        .i_cnt_en           (cnt_en),
        .i_cnt_clr          (cnt_clr),
        .ov_pkt_discard_cnt (discard_cnt)
    );

endmodule

// File: verilog/pkt_discard_counter.sv
module pkt_discard_counter
    import mgmt_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,

    // One pulse per discarded packet
    input  logic       i_pkt_discard,

    // From the control register
    input  logic       i_cnt_en,
    input  logic       i_cnt_clr,

    output mgmt_data_t ov_pkt_discard_cnt
);

    logic at_max;

    // Stop at all ones instead of wrapping
    assign at_max = &ov_pkt_discard_cnt;

    //////////////////////////////////////////////////
    // Event counter
    //////////////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ov_pkt_discard_cnt <= '0;
        end else begin
            if (i_cnt_clr) begin
                // Clear beats a pulse in the same cycle
                ov_pkt_discard_cnt <= '0;
            end else if (i_cnt_en && i_pkt_discard && !at_max) begin
                ov_pkt_discard_cnt <= ov_pkt_discard_cnt + 1'b1;
            end
        end
    end

endmodule

// File: verilog/ctrl_cmd_parse.sv
module ctrl_cmd_parse
    import mgmt_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,

    // Management command from the bridge
    input  mgmt_cmd_t i_cmd,

    // Read answer, zero when not addressed
    output mgmt_rsp_t o_rsp,

    // Counter control
    output logic      o_cnt_en,
    output logic      o_cnt_clr
);

    logic       hit;
    mgmt_data_t ctrl_rdata;

    assign hit = i_cmd.addr_fixed && (i_cmd.addr == ADDR_CNT_CTRL);

    // Clear bit is write-only and always reads back 0
    assign ctrl_rdata = {{(MGMT_DATA_W-1){1'b0}}, o_cnt_en};

    //////////////////////////////////////////////////
    // Control register
    //////////////////////////////////////////////////
    // Bit 0 enables counting, bit 1 fires a clear
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_cnt_en  <= 1'b0;
            o_cnt_clr <= 1'b0;
        end else begin
            o_cnt_clr <= 1'b0;
            if (i_cmd.wr && hit) begin
                o_cnt_en  <= i_cmd.wdata[0];
                o_cnt_clr <= i_cmd.wdata[1];
            end
        end
    end

    //////////////////////////////////////////////////
    // Readback
    //////////////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rsp <= '0;
        end else begin
            if (i_cmd.rd && hit) begin
                o_rsp <= '{valid:      1'b1,
                           addr:       i_cmd.addr,
                           addr_fixed: i_cmd.addr_fixed,
                           rdata:      ctrl_rdata};
            end else begin
                // Writes and foreign reads leave the bus idle
                o_rsp <= '0;
            end
        end
    end

    // One write gives one clear cycle at the counter
    a_clr_pulse: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_cnt_clr |=> !o_cnt_clr
    );

endmodule

// File: verilog/dex_cmd_parse.sv
module dex_cmd_parse
    import mgmt_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,

    // Management command from the bridge
    input  mgmt_cmd_t  i_cmd,

    // Live discard count
    input  mgmt_data_t iv_pkt_discard_cnt,

    // Read answer, zero when not addressed
    output mgmt_rsp_t  o_rsp
);

    logic hit;

    // Discard count lives at a fixed address
    assign hit = i_cmd.addr_fixed && (i_cmd.addr == ADDR_DISCARD_CNT);

    //////////////////////////////////////////////////
    // Registered decode
    //////////////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rsp <= '0;
        end else begin
            if (i_cmd.wr) begin
                // Read-only register so writes are dropped
                o_rsp <= '0;
            end else if (i_cmd.rd && hit) begin
                o_rsp <= '{valid:      1'b1,
                           addr:       i_cmd.addr,
                           addr_fixed: i_cmd.addr_fixed,
                           rdata:      iv_pkt_discard_cnt};
            end else begin
                o_rsp <= '0;
            end
        end
    end

    // One rd strobe gives exactly one answer cycle
    a_rsp_single: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_rsp.valid |=> !o_rsp.valid
    );

endmodule

// File: verilog/axil_cmd_bridge.sv
module axil_cmd_bridge
    import mgmt_pkg::*;
#(
    parameter int N_RSP      = 2,
    parameter int AXI_ADDR_W = 22
) (
    input  logic                        i_clk,
    input  logic                        i_rst_n,

    // Write address and data
    input  logic                        i_awvalid,
    output logic                        o_awready,
    input  logic [AXI_ADDR_W-1:0]       i_awaddr,
    input  logic                        i_wvalid,
    output logic                        o_wready,
    input  mgmt_data_t                  i_wdata,

    // Write response
    output logic                        o_bvalid,
    input  logic                        i_bready,
    output axi_resp_t                   o_bresp,

    // Read address
    input  logic                        i_arvalid,
    output logic                        o_arready,
    input  logic [AXI_ADDR_W-1:0]       i_araddr,

    // Read data
    output logic                        o_rvalid,
    input  logic                        i_rready,
    output mgmt_data_t                  o_rdata,
    output axi_resp_t                   o_rresp,

    // Management command and parser responses
    output mgmt_cmd_t                   o_cmd,
    input  mgmt_rsp_t [N_RSP-1:0]       i_rsp
);

    typedef enum logic [2:0] {
        IDLE,
        WR_RESP,
        RD_CMD,
        RD_WAIT,
        RD_RESP
    } state_t;

    state_t    state;
    logic      idle;
    logic      wr_go;
    logic      rd_go;
    mgmt_rsp_t rsp_or;

    //////////////////////////////////////////////////
    // Handshakes
    //////////////////////////////////////////////////
    assign idle  = (state == IDLE);

    // AW and W are taken together, write wins over read
    assign wr_go = idle && i_awvalid && i_wvalid;
    assign rd_go = idle && i_arvalid && !wr_go;

    assign o_awready = idle && i_wvalid;
    assign o_wready  = idle && i_awvalid;
    assign o_arready = idle && !(i_awvalid && i_wvalid);

    // Writes are never refused
    assign o_bresp = RESP_OKAY;

    //////////////////////////////////////////////////
    // Transaction FSM
    //////////////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= IDLE;
            o_cmd    <= '0;
            o_bvalid <= 1'b0;
            o_rvalid <= 1'b0;
        end else begin
            // Strobes last a single cycle
            o_cmd.wr <= 1'b0;
            o_cmd.rd <= 1'b0;

            case (state)
                IDLE: begin
                    if (wr_go) begin
                        o_cmd <= '{wr:         1'b1,
                                   rd:         1'b0,
                                   addr:       i_awaddr[AXI_ADDR_W-2:2],
                                   addr_fixed: i_awaddr[AXI_ADDR_W-1],
                                   wdata:      i_wdata};
                        o_bvalid <= 1'b1;
                        state    <= WR_RESP;
                    end else if (rd_go) begin
                        o_cmd <= '{wr:         1'b0,
                                   rd:         1'b1,
                                   addr:       i_araddr[AXI_ADDR_W-2:2],
                                   addr_fixed: i_araddr[AXI_ADDR_W-1],
                                   wdata:      '0};
                        state <= RD_CMD;
                    end
                end

                WR_RESP: begin
                    if (i_bready) begin
                        o_bvalid <= 1'b0;
                        state    <= IDLE;
                    end
                end

                // rd strobe is on the bus this cycle
                RD_CMD: begin
                    state <= RD_WAIT;
                end

                // Parser answers are on the bus this cycle
                RD_WAIT: begin
                    o_rvalid <= 1'b1;
                    state    <= RD_RESP;
                end

                RD_RESP: begin
                    if (i_rready) begin
                        o_rvalid <= 1'b0;
                        state    <= IDLE;
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Read response collection
    //////////////////////////////////////////////////
    // Idle parsers drive zero so a plain OR merges them
    always_comb begin
        rsp_or = '0;
        for (int i = 0; i < N_RSP; i++) begin
            rsp_or = rsp_or | i_rsp[i];
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == RD_WAIT) begin
            o_rdata <= rsp_or.valid ? rsp_or.rdata : '0;
            o_rresp <= rsp_or.valid ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // Command bus carries one kind of strobe at a time
    a_cmd_excl: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !(o_cmd.wr && o_cmd.rd)
    );

    // Read data stays put until the host takes it
    a_rvalid_hold: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata) && $stable(o_rresp)
    );

endmodule

// File: verilog/mgmt_pkg.sv
package mgmt_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////
    localparam int MGMT_ADDR_W = 19;
    localparam int MGMT_DATA_W = 32;
    localparam int AXI_RESP_W  = 2;

    typedef logic [MGMT_ADDR_W-1:0] mgmt_addr_t;
    typedef logic [MGMT_DATA_W-1:0] mgmt_data_t;
    typedef logic [AXI_RESP_W-1:0]  axi_resp_t;

    // AXI response codes
    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    // Fixed register space map
    localparam mgmt_addr_t ADDR_DISCARD_CNT = 19'd0;
    localparam mgmt_addr_t ADDR_CNT_CTRL    = 19'd1;

    //////////////////////////////////////////////////
    // Management command and read response
    //////////////////////////////////////////////////
    // One command per cycle, wr and rd never together
    typedef struct packed {
        logic       wr;
        logic       rd;
        mgmt_addr_t addr;
        logic       addr_fixed;
        mgmt_data_t wdata;
    } mgmt_cmd_t;

    // All zero when idle
    typedef struct packed {
        logic       valid;
        mgmt_addr_t addr;
        logic       addr_fixed;
        mgmt_data_t rdata;
    } mgmt_rsp_t;

endpackage
